/* list.f */
+incdir+hdl
hdl/execPkg.sv
hdl/forwardUnit.sv
hdl/aluUnit.sv
hdl/mulUnit.sv
hdl/executeStage.sv
hdl/executeTop.sv
test/execute_assertions.sv
test/executeTb.sv

/* run.sh */
#!/bin/sh
# build and run the execute stage testbench with Verilator, then scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f list.f --top-module executeTb \
   > sim.log 2>&1 &&
./obj_dir/VexecuteTb +verilator+error+limit+1000 >> sim.log 2>&1 ||
echo "build or simulation aborted" >> sim.log
cat sim.log
grep -q "Simulation failed" sim.log && echo "RESULT: FAIL" && exit 1
grep -q "build or simulation aborted" sim.log && echo "RESULT: FAIL" && exit 1
grep -q "Simulation completed successfully" sim.log && echo "RESULT: PASS" && exit 0
echo "RESULT: FAIL"
exit 1

/* test/executeTb.sv */
`include "exec_config.svh"

module executeTb;
   timeunit 1ns;
   timeprecision 100ps;
   import execPkg::*;

   localparam int PERIOD    = 4;
   localparam int SEED      = 15936;
   localparam int MUL_LIMIT = `MUL_CYCLES + 8;
   // cycle budget of each test for the watchdog
   localparam int ALU_CYC   = 9 * 4 + 3;
   localparam int FWD_CYC   = 14;
   localparam int BR_CYC    = 10;
   localparam int MUL_CYC   = 2 * (MUL_LIMIT + 2) + 3;
   localparam int STALL_CYC = 10 + MUL_LIMIT;
   localparam int RST_CYC   = 10;
   localparam int MARGIN    = 40;
   localparam int RUN_CYC   = ALU_CYC + FWD_CYC + BR_CYC + MUL_CYC + STALL_CYC
                              + RST_CYC + MARGIN;

   logic               clk;
   logic               rst;
   exCtrlT             exCtrl;
   exDataT             exData;
   wbFwdT              wbFwd;
   logic               stallM;
   memStageT           memOut;
   logic               pcSrc;
   logic [`WORD_W-1:0] pcTarget;
   logic               mulStall;
   logic [`REG_W-1:0]  hazRs1;
   logic [`REG_W-1:0]  hazRs2;
   logic [`REG_W-1:0]  hazRd;
   logic               hazLoad;
   int                 seenFails;
   int                 extraFails;
   int                 testsPassed;
   int                 testsFailed;

   executeTop UUT (
      .clk      (clk),
      .rst      (rst),
      .exCtrl   (exCtrl),
      .exData   (exData),
      .wbFwd    (wbFwd),
      .stallM   (stallM),
      .memOut   (memOut),
      .pcSrc    (pcSrc),
      .pcTarget (pcTarget),
      .mulStall (mulStall),
      .hazRs1   (hazRs1),
      .hazRs2   (hazRs2),
      .hazRd    (hazRd),
      .hazLoad  (hazLoad)
   );

   initial begin
      clk = 1'b0;
      forever #(PERIOD / 2) clk = ~clk;
   end

   initial begin
      #(RUN_CYC * PERIOD);
      $display("watchdog: run timed out after %0d cycles", RUN_CYC);
      $display("Simulation failed");
      $finish;
   end

   // inputs change 1 ns after the rising edge
   task automatic tick(input int n);
      repeat (n) @(posedge clk);
      #1;
   endtask

   task automatic clearInputs();
      exCtrl = '0;
      exData = '0;
      wbFwd  = '0;
      stallM = 1'b0;
   endtask

   task automatic setOp(input aluOpT op, input logic useImm, input logic [`REG_W-1:0] rs1,
                        input logic [`REG_W-1:0] rs2, input logic [`REG_W-1:0] rd);
      exCtrl          = '0;
      exCtrl.aluOp    = op;
      exCtrl.aluSrc   = useImm;
      exCtrl.regWrite = (rd != '0);
      exData.rs1      = rs1;
      exData.rs2      = rs2;
      exData.rd       = rd;
      exData.rd1      = $urandom;
      exData.rd2      = $urandom;
      exData.immExt   = $urandom;
      exData.pc       = $urandom;
      exData.pcPlus4  = exData.pc + 4;
   endtask

   // hold the multiply until mulStall drops, then let the product latch
   task automatic finishMul();
      int guard;
      guard = 0;
      #1;
      while (mulStall && guard < MUL_LIMIT) begin
         tick(1);
         guard++;
      end
      if (mulStall) begin
         $display("multiply still stalling after %0d cycles", MUL_LIMIT);
         extraFails++;
      end
      tick(1);
   endtask

   task automatic endTest(input string name);
      int newFails;
      clearInputs();
      tick(2);
      newFails   = UUT.uChk.failCount - seenFails + extraFails;
      seenFails  = UUT.uChk.failCount;
      extraFails = 0;
      $display("test %-8s new failures: %0d", name, newFails);
      if (newFails == 0) begin
         testsPassed++;
      end else begin
         testsFailed++;
      end
   endtask

   initial begin
      void'($urandom(SEED));
      seenFails   = 0;
      extraFails  = 0;
      testsPassed = 0;
      testsFailed = 0;
      rst         = 1'b1;
      clearInputs();
      tick(2);
      rst = 1'b0;
      tick(1);

      for (int k = 0; k < 9; k++) begin
         for (int i = 0; i < 4; i++) begin
            setOp(aluOpT'(k), i[0], 5'd1, 5'd2, 5'd3);
            exCtrl.resultSrc  = 2'(i);
            exCtrl.byteAccess = i[1];
            exCtrl.memWrite   = i[0];
            exCtrl.readEnable = ~i[0];
            tick(1);
         end
      end
      endTest("alu");

      // dependent adds through the memory stage
      setOp(ADD, 1'b1, 5'd0, 5'd0, 5'd5);
      tick(1);
      for (int i = 0; i < 4; i++) begin
         setOp(ADD, 1'b1, 5'd5, 5'd0, 5'd5);
         tick(1);
      end
      setOp(ADD, 1'b0, 5'd6, 5'd6, 5'd7);
      wbFwd.result   = $urandom;
      wbFwd.rd       = 5'd6;
      wbFwd.regWrite = 1'b1;
      tick(1);
      // same register in both stages
      setOp(ADD, 1'b0, 5'd0, 5'd0, 5'd6);
      tick(1);
      setOp(SUB, 1'b0, 5'd6, 5'd6, 5'd8);
      tick(1);
      setOp(OR, 1'b0, 5'd0, 5'd0, 5'd0);
      exCtrl.regWrite = 1'b1;
      wbFwd.rd        = 5'd0;
      tick(1);
      setOp(XOR, 1'b0, 5'd0, 5'd0, 5'd9);
      tick(1);
      endTest("forward");

      for (int i = 0; i < 6; i++) begin
         setOp(SUB, 1'b0, 5'd1, 5'd2, 5'd0);
         exCtrl.branch = (i < 4);
         exCtrl.jump   = (i >= 4);
         if (i[0]) begin
            exData.rd2 = exData.rd1;
         end
         tick(1);
      end
      endTest("branch");

      for (int i = 0; i < 2; i++) begin
         setOp(MUL, i[0], 5'd1, 5'd2, 5'd10);
         // memory controls set so the bubble has them to clear
         exCtrl.memWrite   = 1'b1;
         exCtrl.readEnable = 1'b1;
         finishMul();
      end
      endTest("multiply");

      setOp(ADD, 1'b1, 5'd0, 5'd0, 5'd11);
      tick(1);
      stallM = 1'b1;
      for (int i = 0; i < 3; i++) begin
         setOp(XOR, 1'b0, 5'd1, 5'd2, 5'd12);
         tick(1);
      end
      stallM = 1'b0;
      tick(1);
      // multiply frozen part way through
      setOp(MUL, 1'b0, 5'd1, 5'd2, 5'd13);
      tick(1);
      stallM = 1'b1;
      tick(2);
      stallM = 1'b0;
      finishMul();
      endTest("stall");

      setOp(ADD, 1'b1, 5'd0, 5'd0, 5'd14);
      tick(1);
      setOp(MUL, 1'b0, 5'd1, 5'd2, 5'd15);
      tick(1);
      clearInputs();
      rst = 1'b1;
      tick(2);
      rst = 1'b0;
      tick(1);
      endTest("reset");

      $display("tests passed: %0d, tests failed: %0d", testsPassed, testsFailed);
      if (testsFailed == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

/* test/execute_assertions.sv */
`include "exec_config.svh"

module executeAssertions (
   input logic               clk,
   input logic               rst,
   input execPkg::exCtrlT    exCtrl,
   input execPkg::exDataT    exData,
   input execPkg::wbFwdT     wbFwd,
   input logic               stallM,
   input execPkg::memStageT  memOut,
   input logic               pcSrc,
   input logic [`WORD_W-1:0] pcTarget,
   input logic               mulStall,
   input logic [`REG_W-1:0]  hazRs1,
   input logic [`REG_W-1:0]  hazRs2,
   input logic [`REG_W-1:0]  hazRd,
   input logic               hazLoad
);
   timeunit 1ns;
   timeprecision 100ps;
   import execPkg::*;

   localparam int LAST = `MUL_CYCLES - 1;

   int                 failCount = 0;
   int                 mulDone;
   logic [`WORD_W-1:0] refA;
   logic [`WORD_W-1:0] refB;
   logic [`WORD_W-1:0] opB;
   logic [`WORD_W-1:0] refResult;
   logic [`WORD_W-1:0] mulRef;
   logic               isMul;
   logic               expMulStall;

   // expected operands with memory-stage priority over writeback
   always_comb begin
      refA = exData.rd1;
      refB = exData.rd2;
      if (exData.rs1 != '0 && wbFwd.regWrite && wbFwd.rd == exData.rs1) begin
         refA = wbFwd.result;
      end
      if (exData.rs1 != '0 && memOut.regWrite && memOut.rd == exData.rs1) begin
         refA = memOut.aluResult;
      end
      if (exData.rs2 != '0 && wbFwd.regWrite && wbFwd.rd == exData.rs2) begin
         refB = wbFwd.result;
      end
      if (exData.rs2 != '0 && memOut.regWrite && memOut.rd == exData.rs2) begin
         refB = memOut.aluResult;
      end
      opB = exCtrl.aluSrc ? exData.immExt : refB;
      case (exCtrl.aluOp)
         ADD: refResult = refA + opB;
         SUB: refResult = refA + ~opB + 1;
         AND: refResult = refA & opB;
         OR:  refResult = refA | opB;
         XOR: refResult = refA ^ opB;
         SLT: refResult = ($signed(refA) < $signed(opB)) ? 1 : 0;
         SLL: refResult = refA << opB[4:0];
         SRL: refResult = refA >> opB[4:0];
         SRA: refResult = $unsigned($signed(refA) >>> opB[4:0]);
         // MUL keeps only the low word
         default: refResult = refA * opB;
      endcase
   end

   assign isMul       = (exCtrl.aluOp == MUL);
   assign expMulStall = isMul && (mulDone != LAST);

   // counts non-stalled multiply cycles and captures the product on the first
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         mulDone <= 0;
         mulRef  <= '0;
      end else if (!isMul) begin
         mulDone <= 0;
      end else if (!stallM) begin
         if (mulDone == 0) begin
            mulRef <= refResult;
         end
         mulDone <= (mulDone == LAST) ? 0 : mulDone + 1;
      end
   end

   aluResultChk: assert property (@(posedge clk) disable iff (rst)
      !stallM && !isMul |=> memOut.aluResult == $past(refResult))
      else begin
         $error("[FAIL] %0t aluResult differs from the operation rule", $time);
         failCount = failCount + 1;
      end

   ctrlCarryChk: assert property (@(posedge clk) disable iff (rst)
      !stallM && !mulStall |=> memOut.rd == $past(exData.rd)
         && memOut.regWrite == $past(exCtrl.regWrite)
         && memOut.memWrite == $past(exCtrl.memWrite)
         && memOut.resultSrc == $past(exCtrl.resultSrc)
         && memOut.byteAccess == $past(exCtrl.byteAccess)
         && memOut.readEnable == $past(exCtrl.readEnable)
         && memOut.writeData == $past(refB)
         && memOut.pcPlus4 == $past(exData.pcPlus4))
      else begin
         $error("[FAIL] %0t control or store data not carried into memOut", $time);
         failCount = failCount + 1;
      end

   hazChk: assert property (@(posedge clk) disable iff (rst)
      hazRs1 == exData.rs1 && hazRs2 == exData.rs2 && hazRd == exData.rd
         && hazLoad == exCtrl.readEnable)
      else begin
         $error("[FAIL] %0t hazard outputs do not match the instruction in execute", $time);
         failCount = failCount + 1;
      end

   targetChk: assert property (@(posedge clk) disable iff (rst)
      pcTarget == exData.pc + exData.immExt)
      else begin
         $error("[FAIL] %0t pcTarget is not pc plus immediate", $time);
         failCount = failCount + 1;
      end

   pcSrcChk: assert property (@(posedge clk) disable iff (rst)
      !isMul |-> pcSrc == (exCtrl.jump || (exCtrl.branch && refResult == '0)))
      else begin
         $error("[FAIL] %0t pcSrc wrong for branch or jump", $time);
         failCount = failCount + 1;
      end

   mulStallChk: assert property (@(posedge clk) disable iff (rst)
      mulStall == expMulStall)
      else begin
         $error("[FAIL] %0t mulStall length wrong", $time);
         failCount = failCount + 1;
      end

   bubbleChk: assert property (@(posedge clk) disable iff (rst)
      mulStall && !stallM |=> !memOut.regWrite && !memOut.memWrite && !memOut.readEnable)
      else begin
         $error("[FAIL] %0t memOut is not a bubble during multiply", $time);
         failCount = failCount + 1;
      end

   productChk: assert property (@(posedge clk) disable iff (rst)
      isMul && !stallM && mulDone == LAST |=> memOut.aluResult == $past(mulRef))
      else begin
         $error("[FAIL] %0t multiply low word wrong", $time);
         failCount = failCount + 1;
      end

   freezeChk: assert property (@(posedge clk) disable iff (rst)
      stallM |=> memOut == $past(memOut))
      else begin
         $error("[FAIL] %0t memOut changed under stallM", $time);
         failCount = failCount + 1;
      end

   resetChk: assert property (@(posedge clk)
      $fell(rst) |-> memOut == '0 && !mulStall && !pcSrc)
      else begin
         $error("[FAIL] %0t outputs not cleared after reset", $time);
         failCount = failCount + 1;
      end

endmodule

bind executeTop executeAssertions uChk (
   .clk      (clk),
   .rst      (rst),
   .exCtrl   (exCtrl),
   .exData   (exData),
   .wbFwd    (wbFwd),
   .stallM   (stallM),
   .memOut   (memOut),
   .pcSrc    (pcSrc),
   .pcTarget (pcTarget),
   .mulStall (mulStall),
   .hazRs1   (hazRs1),
   .hazRs2   (hazRs2),
   .hazRd    (hazRd),
   .hazLoad  (hazLoad)
);

/* hdl/executeTop.sv */
`include "exec_config.svh"

module executeTop (
   input  logic               clk,
   input  logic               rst,
   input  execPkg::exCtrlT    exCtrl,
   input  execPkg::exDataT    exData,
   input  execPkg::wbFwdT     wbFwd,
   input  logic               stallM,
   output execPkg::memStageT  memOut,
   output logic               pcSrc,
   output logic [`WORD_W-1:0] pcTarget,
   output logic               mulStall,
   output logic [`REG_W-1:0]  hazRs1,
   output logic [`REG_W-1:0]  hazRs2,
   output logic [`REG_W-1:0]  hazRd,
   output logic               hazLoad
);

   logic [`WORD_W-1:0] srcA;
   logic [`WORD_W-1:0] fwdB;

   // memOut doubles as the memory-stage forward source
   forwardUnit uFwd (
      .exData (exData),
      .memFwd (memOut),
      .wbFwd  (wbFwd),
      .srcA   (srcA),
      .fwdB   (fwdB)
   );

   executeStage uExec (
      .clk      (clk),
      .rst      (rst),
      .exCtrl   (exCtrl),
      .exData   (exData),
      .srcA     (srcA),
      .fwdB     (fwdB),
      .stallM   (stallM),
      .memOut   (memOut),
      .pcSrc    (pcSrc),
      .pcTarget (pcTarget),
      .mulStall (mulStall),
      .hazRs1   (hazRs1),
      .hazRs2   (hazRs2),
      .hazRd    (hazRd),
      .hazLoad  (hazLoad)
   );

endmodule

/* hdl/executeStage.sv */
`include "exec_config.svh"

module executeStage (
   input  logic               clk,
   input  logic               rst,
   input  execPkg::exCtrlT    exCtrl,
   input  execPkg::exDataT    exData,
   input  logic [`WORD_W-1:0] srcA,
   input  logic [`WORD_W-1:0] fwdB,
   input  logic               stallM,
   output execPkg::memStageT  memOut,
   output logic               pcSrc,
   output logic [`WORD_W-1:0] pcTarget,
   output logic               mulStall,
   output logic [`REG_W-1:0]  hazRs1,
   output logic [`REG_W-1:0]  hazRs2,
   output logic [`REG_W-1:0]  hazRd,
   output logic               hazLoad
);
   import execPkg::*;

   logic [`WORD_W-1:0] srcB;
   logic [`WORD_W-1:0] aluResult;
   logic [`WORD_W-1:0] mulProduct;
   logic [`WORD_W-1:0] exResult;
   logic               zero;
   logic               isMul;
   logic               mulBusy;
   memStageT           nextMem;

   // immediate or forwarded register for operand B
   assign srcB = exCtrl.aluSrc ? exData.immExt : fwdB;

   assign isMul = (exCtrl.aluOp == MUL);

   aluUnit uAlu (
      .aluOp  (exCtrl.aluOp),
      .a      (srcA),
      .b      (srcB),
      .result (aluResult),
      .zero   (zero)
   );

   // multiplier counter freezes together with the E/M register
   mulUnit uMul (
      .clk     (clk),
      .rst     (rst),
      .start   (isMul),
      .hold    (stallM),
      .a       (srcA),
      .b       (srcB),
      .product (mulProduct),
      .busy    (mulBusy)
   );

   assign exResult = isMul ? mulProduct : aluResult;
   assign mulStall = mulBusy;

   // branch and jump resolution
   assign pcTarget = exData.pc + exData.immExt;
   assign pcSrc    = exCtrl.jump | (exCtrl.branch & zero);

   // instruction in execute, for the load-use detector
   assign hazRs1  = exData.rs1;
   assign hazRs2  = exData.rs2;
   assign hazRd   = exData.rd;
   assign hazLoad = exCtrl.readEnable;

   // bubble while the multiply is still running
   always_comb begin
      nextMem.aluResult  = exResult;
      nextMem.writeData  = fwdB;
      nextMem.pcPlus4    = exData.pcPlus4;
      nextMem.rd         = exData.rd;
      nextMem.regWrite   = exCtrl.regWrite & ~mulStall;
      nextMem.memWrite   = exCtrl.memWrite & ~mulStall;
      nextMem.resultSrc  = exCtrl.resultSrc;
      nextMem.byteAccess = exCtrl.byteAccess;
      nextMem.readEnable = exCtrl.readEnable & ~mulStall;
   end

   // execute/memory register, held while memory stalls
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         memOut <= '0;
      end else if (!stallM) begin
         memOut <= nextMem;
      end
   end

endmodule

/* hdl/mulUnit.sv */
`include "exec_config.svh"

module mulUnit (
   input  logic               clk,
   input  logic               rst,
   input  logic               start,
   input  logic               hold,
   input  logic [`WORD_W-1:0] a,
   input  logic [`WORD_W-1:0] b,
   output logic [`WORD_W-1:0] product,
   output logic               busy
);
   localparam int W     = `WORD_W;
   localparam int GRP_W = `WORD_W / `MUL_CYCLES;
   localparam int CNT_W = $clog2(`MUL_CYCLES);
   localparam logic [CNT_W-1:0] LAST = CNT_W'(`MUL_CYCLES - 1);

   logic [CNT_W-1:0] cnt;
   logic [W-1:0]     aReg;
   logic [W-1:0]     bReg;
   logic [W-1:0]     acc;
   logic [W-1:0]     opA;
   logic [W-1:0]     opB;
   logic [W-1:0]     accIn;
   logic [W-1:0]     partial;
   logic [GRP_W-1:0] grp;
   logic             advance;

   assign advance = start && !hold;

   // first cycle uses the live operands, later ones the latched copies
   assign opA   = (cnt == '0) ? a : aReg;
   assign opB   = (cnt == '0) ? b : bReg;
   assign accIn = (cnt == '0) ? '0 : acc;

   // one group of multiplier bits per cycle, lowest group first
   assign grp     = GRP_W'(opB >> (int'(cnt) * GRP_W));
   assign partial = (opA * {{(W-GRP_W){1'b0}}, grp}) << (int'(cnt) * GRP_W);
   assign product = accIn + partial;

   // final cycle no longer stalls, product is complete then
   assign busy = start && (cnt != LAST);

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         cnt <= '0;
      end else if (!start) begin
         cnt <= '0;
      end else if (!hold) begin
         cnt <= (cnt == LAST) ? '0 : cnt + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (advance) begin
         acc <= product;
         if (cnt == '0) begin
            aReg <= a;
            bReg <= b;
         end
      end
   end

endmodule

/* hdl/aluUnit.sv */
`include "exec_config.svh"

module aluUnit (
   input  execPkg::aluOpT     aluOp,
   input  logic [`WORD_W-1:0] a,
   input  logic [`WORD_W-1:0] b,
   output logic [`WORD_W-1:0] result,
   output logic               zero
);
   import execPkg::*;

   localparam int W = `WORD_W;

   logic [4:0] shamt;
   logic       lessThan;

   // shift amount from the low five bits only
   assign shamt = b[4:0];

   // signed compare for SLT
   assign lessThan = $signed(a) < $signed(b);

   always_comb begin
      case (aluOp)
         ADD: begin
            result = a + b;
         end
         SUB: begin
            result = a - b;
         end
         AND: begin
            result = a & b;
         end
         OR: begin
            result = a | b;
         end
         XOR: begin
            result = a ^ b;
         end
         SLT: begin
            result = {{(W-1){1'b0}}, lessThan};
         end
         SLL: begin
            result = a << shamt;
         end
         SRL: begin
            result = a >> shamt;
         end
         SRA: begin
            result = $signed(a) >>> shamt;
         end
         default: begin
            // MUL and unused codes, the product comes from mulUnit
            result = '0;
         end
      endcase
   end

   // branch compare uses SUB, so zero means equal operands
   assign zero = (result == '0);

endmodule

/* hdl/forwardUnit.sv */
`include "exec_config.svh"

module forwardUnit (
   input  execPkg::exDataT   exData,
   input  execPkg::memStageT memFwd,
   input  execPkg::wbFwdT    wbFwd,
   output logic [`WORD_W-1:0] srcA,
   output logic [`WORD_W-1:0] fwdB
);
   import execPkg::*;

   fwdSelT selA;
   fwdSelT selB;

   // memory stage is younger, so it wins over writeback
   function automatic fwdSelT pickSrc(input logic [`REG_W-1:0] rs);
      if (rs == '0) begin
         return REGFILE;
      end else if (memFwd.regWrite && memFwd.rd == rs) begin
         return FROM_M;
      end else if (wbFwd.regWrite && wbFwd.rd == rs) begin
         return FROM_W;
      end
      return REGFILE;
   endfunction

   function automatic logic [`WORD_W-1:0] fwdMux(input fwdSelT sel,
                                                 input logic [`WORD_W-1:0] regVal);
      case (sel)
         FROM_M:  return memFwd.aluResult;
         FROM_W:  return wbFwd.result;
         default: return regVal;
      endcase
   endfunction

   always_comb begin
      selA = pickSrc(exData.rs1);
      selB = pickSrc(exData.rs2);
   end

   // fwdB also serves as store data, so no immediate here
   always_comb begin
      srcA = fwdMux(selA, exData.rd1);
      fwdB = fwdMux(selB, exData.rd2);
   end

endmodule

/* hdl/execPkg.sv */
`include "exec_config.svh"

package execPkg;

   // ALU operations, MUL goes to the iterative multiplier
   typedef enum logic [3:0] {
      ADD = 4'd0,
      SUB = 4'd1,
      AND = 4'd2,
      OR  = 4'd3,
      XOR = 4'd4,
      SLT = 4'd5,
      SLL = 4'd6,
      SRL = 4'd7,
      SRA = 4'd8,
      MUL = 4'd9
   } aluOpT;

   // operand source after forwarding
   typedef enum logic [1:0] {
      REGFILE = 2'd0,
      FROM_W  = 2'd1,
      FROM_M  = 2'd2
   } fwdSelT;

   // control fields decoded for the execute stage
   typedef struct packed {
      aluOpT      aluOp;
      logic       aluSrc;
      logic       branch;
      logic       jump;
      logic       regWrite;
      logic       memWrite;
      logic [1:0] resultSrc;
      logic       byteAccess;
      logic       readEnable;
   } exCtrlT;

   // operands and register indices from decode
   typedef struct packed {
      logic [`WORD_W-1:0] rd1;
      logic [`WORD_W-1:0] rd2;
      logic [`WORD_W-1:0] pc;
      logic [`WORD_W-1:0] immExt;
      logic [`WORD_W-1:0] pcPlus4;
      logic [`REG_W-1:0]  rs1;
      logic [`REG_W-1:0]  rs2;
      logic [`REG_W-1:0]  rd;
   } exDataT;

   // contents of the execute/memory register
   typedef struct packed {
      logic [`WORD_W-1:0] aluResult;
      logic [`WORD_W-1:0] writeData;
      logic [`WORD_W-1:0] pcPlus4;
      logic [`REG_W-1:0]  rd;
      logic               regWrite;
      logic               memWrite;
      logic [1:0]         resultSrc;
      logic               byteAccess;
      logic               readEnable;
   } memStageT;

   // writeback result fed back for forwarding
   typedef struct packed {
      logic [`WORD_W-1:0] result;
      logic [`REG_W-1:0]  rd;
      logic               regWrite;
   } wbFwdT;

endpackage

/* hdl/exec_config.svh */
`ifndef EXEC_CONFIG_SVH
`define EXEC_CONFIG_SVH

// data path width
`define WORD_W 32

// register index width, 32 architectural registers
`define REG_W 5

// cycles a multiply occupies the execute stage
// WORD_W must divide evenly by this, one byte group per cycle at 32/4
`define MUL_CYCLES 4

`endif
